// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module dctTopTb \
		-f dctTop.f --Mdir obj_dir -o dctSim
	./obj_dir/dctSim | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/dctRefModel.svh ====
`ifndef DCT_REF_MODEL_SVH
`define DCT_REF_MODEL_SVH

// integer model of the 2D DCT, included inside the testbench module

localparam int refFracBits = 14;
localparam longint refHalf = 64'sd1 << (refFracBits - 1);

// c(k)*cos((2n+1)k*pi/16)*2^14, row k is the frequency
localparam int refMatrix [8][8] = '{
	'{ 5793,  5793,  5793,  5793,  5793,  5793,  5793,  5793},
	'{ 8035,  6811,  4551,  1598, -1598, -4551, -6811, -8035},
	'{ 7568,  3135, -3135, -7568, -7568, -3135,  3135,  7568},
	'{ 6811, -1598, -8035, -4551,  4551,  8035,  1598, -6811},
	'{ 5793, -5793, -5793,  5793,  5793, -5793, -5793,  5793},
	'{ 4551, -8035,  1598,  6811, -6811, -1598,  8035, -4551},
	'{ 3135, -7568,  7568, -3135, -3135,  7568, -7568,  3135},
	'{ 1598, -4551,  6811, -8035,  8035, -6811,  4551, -1598}
};

// pixels in row-major order, and the coefficients at v*8+u
int refPixels [64];
int refCoefs [64];

// round half up, keep 11 bits as a signed value
function automatic int roundRef(input longint acc);
	longint scaled;
	int low;

	scaled = (acc + refHalf) >>> refFracBits;
	low = int'(scaled & 64'sd2047);
	if (low > 1023) begin
		low = low - 2048;
	end
	return low;
endfunction

task automatic computeReference();
	int rowOut [8][8];
	longint sum;

	// horizontal pass on level-shifted pixels
	for (int r = 0; r < 8; r++) begin
		for (int u = 0; u < 8; u++) begin
			sum = 0;
			for (int n = 0; n < 8; n++) begin
				sum = sum + longint'(refPixels[r*8+n] - 128) * refMatrix[u][n];
			end
			rowOut[r][u] = roundRef(sum);
		end
	end

	// vertical pass over the rounded rows
	for (int v = 0; v < 8; v++) begin
		for (int u = 0; u < 8; u++) begin
			sum = 0;
			for (int r = 0; r < 8; r++) begin
				sum = sum + longint'(refMatrix[v][r]) * rowOut[r][u];
			end
			refCoefs[v*8+u] = roundRef(sum);
		end
	end
endtask

`endif

// ==== bench/dctTopTb.sv ====
`timescale 1ns/10ps

module dctTopTb;

	`include "dctRefModel.svh"

	typedef logic signed [10:0] refCoef_t;
	typedef refCoef_t [63:0] expBlock_t;

	logic clk = 1'b0;
	logic rst;
	logic pixelValid;
	logic [7:0] pixel;
	logic blockValid;
	dctTypesPkg::coefBlock_t coefBlock;

	integer seed;
	int valueErrors = 0;
	int timeoutErrors = 0;
	int otherErrors = 0;

	// blocks sent but not yet seen at the output
	expBlock_t expectQ [$];

	// strobe count within the block and a delay line for the 64th one
	int pixelCount;
	logic [3:0] lastPixelPipe;
	dctTypesPkg::coefBlock_t heldBlock;

	dctTop i_dut (
		.clk        (clk),
		.rst        (rst),
		.pixelValid (pixelValid),
		.pixel      (pixel),
		.blockValid (blockValid),
		.coefBlock  (coefBlock)
	);

	always #10 clk = ~clk;

	// a block strobe never lasts two cycles
	pulseWidthCheck: assert property (
		@(posedge clk) disable iff (rst) blockValid |=> !blockValid)
		else begin
			valueErrors++;
			$display("** Error at %0t: blockValid expected 0, got 1", $time);
		end

	task automatic compareBlock();
		expBlock_t expected;

		if (expectQ.size() == 0) begin
			otherErrors++;
			$display("blockValid pulsed at %0t although no complete block was sent", $time);
		end else begin
			expected = expectQ.pop_front();
			for (int i = 0; i < 64; i++) begin
				assert ($signed(coefBlock[i]) == $signed(expected[i])) else begin
					valueErrors++;
					$display("** Error at %0t: coefBlock[%0d] expected %0d, got %0d",
						$time, i, $signed(expected[i]), $signed(coefBlock[i]));
				end
			end
		end
	endtask

	// DUT outputs read here are the values from before this edge
	always @(posedge clk) begin
		if (rst) begin
			pixelCount <= 0;
			lastPixelPipe <= '0;
			heldBlock = coefBlock;
		end else begin
			// strobe exactly three edges after the 64th pixel
			assert (blockValid === lastPixelPipe[3]) else begin
				valueErrors++;
				$display("** Error at %0t: blockValid expected %0b, got %0b",
					$time, lastPixelPipe[3], blockValid);
			end
			if (blockValid) begin
				compareBlock();
				heldBlock = coefBlock;
			end else begin
				assert (coefBlock === heldBlock) else begin
					valueErrors++;
					$display("** Error at %0t: coefBlock expected %h, got %h",
						$time, heldBlock, coefBlock);
				end
			end
			lastPixelPipe <= {lastPixelPipe[2:0], pixelValid && (pixelCount == 63)};
			if (pixelValid) begin
				pixelCount <= (pixelCount == 63) ? 0 : pixelCount + 1;
			end
		end
	end

	task automatic applyReset();
		rst = 1'b1;
		pixelValid = 1'b0;
		repeat (16) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic idleCycles(input int count);
		repeat (count) begin
			@(negedge clk);
			pixelValid = 1'b0;
		end
	endtask

	task automatic fillConstant(input int value);
		for (int i = 0; i < 64; i++) begin
			refPixels[i] = value;
		end
	endtask

	task automatic fillRandom();
		for (int i = 0; i < 64; i++) begin
			refPixels[i] = $random(seed) & 255;
		end
	endtask

	// last strobe stays high until the caller drops it
	task automatic drivePixels(input int count, input int maxGap, input int pauseBeforeLast);
		int gap;

		for (int i = 0; i < count; i++) begin
			gap = 0;
			if (maxGap > 0) begin
				gap = $unsigned($random(seed)) % (maxGap + 1);
			end
			if (i == 63) begin
				gap = gap + pauseBeforeLast;
			end
			repeat (gap) begin
				@(negedge clk);
				pixelValid = 1'b0;
				// junk on the bus while no strobe
				pixel = 8'($random(seed));
			end
			@(negedge clk);
			pixelValid = 1'b1;
			pixel = 8'(refPixels[i]);
		end
	endtask

	task automatic sendBlock(input int maxGap, input int pauseBeforeLast);
		expBlock_t expected;

		computeReference();
		for (int i = 0; i < 64; i++) begin
			expected[i] = refCoef_t'(refCoefs[i]);
		end
		expectQ.push_back(expected);
		drivePixels(64, maxGap, pauseBeforeLast);
	endtask

	task automatic waitForBlocks(input int limit);
		int cycles;

		cycles = 0;
		@(negedge clk);
		pixelValid = 1'b0;
		while (expectQ.size() != 0 && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (expectQ.size() != 0) begin
			timeoutErrors++;
			$display("timeout at %0t: %0d block(s) never came out of the DUT",
				$time, expectQ.size());
			expectQ.delete();
		end
	endtask

	initial begin
		seed = 32'ha07b_68a2;
		rst = 1'b1;
		pixelValid = 1'b0;
		pixel = '0;
		applyReset();

		// nothing may come out before any pixel
		idleCycles(20);

		// flat mid-grey with a long pause before the 64th pixel
		fillConstant(128);
		sendBlock(0, 12);
		waitForBlocks(100);

		// flat white gives DC only
		fillConstant(255);
		sendBlock(0, 0);
		waitForBlocks(100);

		// back-to-back strobes
		fillRandom();
		sendBlock(0, 0);
		waitForBlocks(100);

		// random gaps between strobes
		repeat (3) begin
			fillRandom();
			sendBlock(3, 0);
			waitForBlocks(100);
		end

		// two blocks with no idle cycle between them
		fillRandom();
		sendBlock(0, 0);
		fillRandom();
		sendBlock(0, 0);
		waitForBlocks(100);

		// seven rows then a reset while the last row is in flight
		fillRandom();
		drivePixels(56, 0, 0);
		idleCycles(1);
		applyReset();
		fillRandom();
		sendBlock(1, 0);
		waitForBlocks(100);

		idleCycles(10);
		$display("errors: %0d value, %0d timeout, %0d other",
			valueErrors, timeoutErrors, otherErrors);
		if (valueErrors + timeoutErrors + otherErrors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== dctTop.f ====
+incdir+rtl
+incdir+bench
rtl/dctTypesPkg.sv
rtl/dctMatrixPkg.sv
rtl/dctRowTransform.sv
rtl/dctColumnTransform.sv
rtl/dctTop.sv
bench/dctTopTb.sv

// ==== rtl/dctColumnTransform.sv ====
`timescale 1ns/10ps
`include "dct_settings.svh"

module dctColumnTransform (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    rowValid,
	input  dctTypesPkg::rowCoefs_t  rowCoefs,
	output logic                    blockValid,
	output dctTypesPkg::coefBlock_t coefBlock
);

	localparam int blockSize = `DCT_SIZE * `DCT_SIZE;

	// which row of the block arrives next
	logic [2:0] row;

	// 8th row accumulated, rounding due next edge
	logic blockDone;

	logic signed [`DCT_COL_ACC_WIDTH-1:0] product [blockSize];
	logic signed [`DCT_COL_ACC_WIDTH-1:0] acc [blockSize];

	// accumulator (v, u) sits at v*8+u
	always_comb begin
		for (int v = 0; v < `DCT_SIZE; v++) begin
			for (int u = 0; u < `DCT_SIZE; u++) begin
				product[v*`DCT_SIZE+u] = $signed(rowCoefs[u])
					* dctMatrixPkg::matrixAt(3'(v), row);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			row       <= '0;
			blockDone <= 1'b0;
		end else begin
			blockDone <= rowValid && (row == 3'(`DCT_SIZE - 1));
			if (rowValid) begin
				row <= row + 3'd1;
			end
		end
	end

	// row zero loads, so a new block needs no clearing pass
	always_ff @(posedge clk) begin
		if (rowValid) begin
			for (int i = 0; i < blockSize; i++) begin
				if (row == 3'd0) begin
					acc[i] <= product[i];
				end else begin
					acc[i] <= acc[i] + product[i];
				end
			end
		end
	end

	// all 64 sums rounded together
	always_ff @(posedge clk) begin
		if (rst) begin
			blockValid <= 1'b0;
			coefBlock  <= '0;
		end else begin
			blockValid <= blockDone;
			if (blockDone) begin
				for (int i = 0; i < blockSize; i++) begin
					coefBlock[i] <= dctMatrixPkg::roundFixed(acc[i]);
				end
			end
		end
	end

endmodule

// ==== rtl/dctMatrixPkg.sv ====
`include "dct_settings.svh"

package dctMatrixPkg;

	typedef logic signed [`DCT_MATRIX_WIDTH-1:0] matrixEntry_t;

	// c(k)*cos((2n+1)k*pi/16) scaled by 2^14, row k is the frequency
	localparam matrixEntry_t dctMatrix [`DCT_SIZE][`DCT_SIZE] = '{
		'{ 15'sd5793,  15'sd5793,  15'sd5793,  15'sd5793,
		   15'sd5793,  15'sd5793,  15'sd5793,  15'sd5793},
		'{ 15'sd8035,  15'sd6811,  15'sd4551,  15'sd1598,
		  -15'sd1598, -15'sd4551, -15'sd6811, -15'sd8035},
		'{ 15'sd7568,  15'sd3135, -15'sd3135, -15'sd7568,
		  -15'sd7568, -15'sd3135,  15'sd3135,  15'sd7568},
		'{ 15'sd6811, -15'sd1598, -15'sd8035, -15'sd4551,
		   15'sd4551,  15'sd8035,  15'sd1598, -15'sd6811},
		'{ 15'sd5793, -15'sd5793, -15'sd5793,  15'sd5793,
		   15'sd5793, -15'sd5793, -15'sd5793,  15'sd5793},
		'{ 15'sd4551, -15'sd8035,  15'sd1598,  15'sd6811,
		  -15'sd6811, -15'sd1598,  15'sd8035, -15'sd4551},
		'{ 15'sd3135, -15'sd7568,  15'sd7568, -15'sd3135,
		  -15'sd3135,  15'sd7568, -15'sd7568,  15'sd3135},
		'{ 15'sd1598, -15'sd4551,  15'sd6811, -15'sd8035,
		   15'sd8035, -15'sd6811,  15'sd4551, -15'sd1598}
	};

	// half an LSB of the rounded result
	localparam logic signed [`DCT_COL_ACC_WIDTH-1:0] roundHalf =
		`DCT_COL_ACC_WIDTH'(1) << (`DCT_FRAC_BITS - 1);

	// entry for frequency k at sample position n
	function automatic matrixEntry_t matrixAt(
		input logic [2:0] k,
		input logic [2:0] n
	);
		return dctMatrix[k][n];
	endfunction

	// round half up, then drop the fraction bits
	// row accumulators are sign extended on the way in
	function automatic dctTypesPkg::coef_t roundFixed(
		input logic signed [`DCT_COL_ACC_WIDTH-1:0] acc
	);
		logic signed [`DCT_COL_ACC_WIDTH-1:0] biased;
		logic signed [`DCT_COL_ACC_WIDTH-1:0] scaled;

		biased = acc + roundHalf;
		scaled = biased >>> `DCT_FRAC_BITS;
		return dctTypesPkg::coef_t'(scaled[`DCT_COEF_WIDTH-1:0]);
	endfunction

endpackage

// ==== rtl/dctRowTransform.sv ====
`timescale 1ns/10ps
`include "dct_settings.svh"

module dctRowTransform (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   pixelValid,
	input  dctTypesPkg::pixel_t    pixel,
	output logic                   rowValid,
	output dctTypesPkg::rowCoefs_t rowCoefs
);

	// position of the next pixel inside its row
	logic [2:0] column;

	// last pixel of a row went into the accumulators
	logic rowDone;

	dctTypesPkg::shiftedPixel_t shifted;

	logic signed [`DCT_ROW_ACC_WIDTH-1:0] product [`DCT_SIZE];
	logic signed [`DCT_ROW_ACC_WIDTH-1:0] acc [`DCT_SIZE];

	// level shift centres the pixel on zero
	assign shifted = dctTypesPkg::shiftedPixel_t'({1'b0, pixel})
		- dctTypesPkg::shiftedPixel_t'(`DCT_LEVEL_SHIFT);

	// one product per horizontal frequency
	always_comb begin
		for (int u = 0; u < `DCT_SIZE; u++) begin
			product[u] = shifted * dctMatrixPkg::matrixAt(3'(u), column);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			column  <= '0;
			rowDone <= 1'b0;
		end else begin
			rowDone <= pixelValid && (column == 3'(`DCT_SIZE - 1));
			if (pixelValid) begin
				// wraps to zero after the 8th pixel
				column <= column + 3'd1;
			end
		end
	end

	// column zero starts a fresh row, no separate clear needed
	always_ff @(posedge clk) begin
		if (pixelValid) begin
			for (int u = 0; u < `DCT_SIZE; u++) begin
				if (column == 3'd0) begin
					acc[u] <= product[u];
				end else begin
					acc[u] <= acc[u] + product[u];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rowValid <= 1'b0;
		end else begin
			rowValid <= rowDone;
		end
	end

	// accumulators may already be reloading for the next row here,
	// the old sums are still read on this edge
	always_ff @(posedge clk) begin
		if (rowDone) begin
			for (int u = 0; u < `DCT_SIZE; u++) begin
				rowCoefs[u] <= dctMatrixPkg::roundFixed(acc[u]);
			end
		end
	end

endmodule

// ==== rtl/dctTop.sv ====
`timescale 1ns/10ps

module dctTop (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    pixelValid,
	input  dctTypesPkg::pixel_t     pixel,
	output logic                    blockValid,
	output dctTypesPkg::coefBlock_t coefBlock
);

	// horizontal pass result, one row at a time
	logic                   rowValid;
	dctTypesPkg::rowCoefs_t rowCoefs;

	dctRowTransform i_rowTransform (
		.clk        (clk),
		.rst        (rst),
		.pixelValid (pixelValid),
		.pixel      (pixel),
		.rowValid   (rowValid),
		.rowCoefs   (rowCoefs)
	);

	// vertical pass over the eight rows of a block
	dctColumnTransform i_columnTransform (
		.clk        (clk),
		.rst        (rst),
		.rowValid   (rowValid),
		.rowCoefs   (rowCoefs),
		.blockValid (blockValid),
		.coefBlock  (coefBlock)
	);

endmodule

// ==== rtl/dctTypesPkg.sv ====
`include "dct_settings.svh"

package dctTypesPkg;

	// raw unsigned pixel as it arrives
	typedef logic [`DCT_PIXEL_WIDTH-1:0] pixel_t;

	// pixel minus 128, range -128..127
	typedef logic signed [`DCT_PIXEL_WIDTH:0] shiftedPixel_t;

	// rounded transform value
	typedef logic signed [`DCT_COEF_WIDTH-1:0] coef_t;

	// one row after the horizontal pass, index u
	typedef coef_t [`DCT_SIZE-1:0] rowCoefs_t;

	// whole block, index v*8+u
	typedef coef_t [`DCT_SIZE*`DCT_SIZE-1:0] coefBlock_t;

endpackage

// ==== rtl/dct_settings.svh ====
`ifndef DCT_SETTINGS_SVH
`define DCT_SETTINGS_SVH

// block geometry
`define DCT_SIZE 8

// input samples
`define DCT_PIXEL_WIDTH 8
`define DCT_LEVEL_SHIFT 128

// fixed-point cosine matrix, 14 fraction bits
`define DCT_MATRIX_WIDTH 15
`define DCT_FRAC_BITS 14

// row results and final coefficients share one width
`define DCT_COEF_WIDTH 11

// accumulators hold eight full-precision products
`define DCT_ROW_ACC_WIDTH 26
`define DCT_COL_ACC_WIDTH 28

`endif
